// ==== dv/harness_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module harness_properties (
    input wire clk,
    input wire rst_n_i,
    input wire core_rst_i,
    input wire core_stb_i,
    input wire core_ack_i,
    input wire tx_valid_i
);

    int prop_fails = 0;

    // Core ack lasts one cycle
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        core_ack_i |=> !core_ack_i)
    else begin
        prop_fails++;
        $error("core ack held longer than one cycle");
    end

    // A fresh core request is answered on the next cycle
    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        (core_stb_i && !core_ack_i && !core_rst_i) |=> core_ack_i)
    else begin
        prop_fails++;
        $error("core ack missing one cycle after stb");
    end

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(core_ack_i) |-> $past(core_stb_i))
    else begin
        prop_fails++;
        $error("core ack rose without a request");
    end

    // Core held in reset never gets an ack
    no_ack_in_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
        core_rst_i |-> !$rose(core_ack_i))
    else begin
        prop_fails++;
        $error("core ack rose while the core was held");
    end

    // Read replies are exactly four bytes long
    tx_run_of_four: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(tx_valid_i) |=> tx_valid_i ##1 tx_valid_i ##1 tx_valid_i ##1 !tx_valid_i)
    else begin
        prop_fails++;
        $error("tx valid run is not four cycles");
    end

endmodule

bind harness_top harness_properties u_props (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .core_rst_i (core_rst_o),
    .core_stb_i (core_stb_i),
    .core_ack_i (core_ack_o),
    .tx_valid_i (tx_valid_o)
);

`default_nettype wire

// ==== dv/harness_tb.sv ====
`timescale 1ns/1ps
`include "harness_settings.svh"
`default_nettype none

module harness_tb;
    import harness_pkg::*;

    localparam int NWORDS     = 8;
    // Boot plus about 60 cycles per word over all tests, doubled
    localparam int TEST_LEN   = 8 + `HARNESS_BOOT_CYCLES + 10 + NWORDS * 60;
    localparam int MAX_CYCLES = 2 * TEST_LEN;

    logic  clk = 1'b0;
    logic  rst_n_i;
    byte_t rx_byte_i;
    logic  rx_valid_i;
    byte_t tx_byte_o;
    logic  tx_valid_o;
    logic  core_rst_o;
    logic  core_stb_i;
    logic  core_we_i;
    addr_t core_addr_i;
    word_t core_wdata_i;
    word_t core_rdata_o;
    logic  core_ack_o;

    word_t       model [1 << `HARNESS_ADDR_W];
    addr_t       addrs [NWORDS];
    logic [31:0] seed      = 32'he196_ad72;
    int          cycles    = 0;
    int          checks    = 0;
    int          errors    = 0;
    int          test_base = 0;

    harness_top uut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run passed %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    function automatic word_t next_word();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp)
        else begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input byte_t b);
        rx_byte_i  = b;
        rx_valid_i = 1'b1;
        step(1);
        rx_valid_i = 1'b0;
    endtask

    task automatic host_write(input addr_t a, input word_t d);
        logic [15:0] a16;
        a16 = 16'(a);
        send_byte(WRITE);
        send_byte(a16[15:8]);
        send_byte(a16[7:0]);
        for (int k = 3; k >= 0; k--) begin
            send_byte(d[8*k +: 8]);
        end
        step(3);
    endtask

    task automatic host_read(input addr_t a, output word_t d);
        logic [15:0] a16;
        int          wait_cnt;
        a16      = 16'(a);
        wait_cnt = 0;
        d        = '0;
        send_byte(READ);
        send_byte(a16[15:8]);
        send_byte(a16[7:0]);
        while (!tx_valid_o && wait_cnt < 10) begin
            step(1);
            wait_cnt++;
        end
        assert (tx_valid_o)
        else begin
            $display("No read reply for address %h", a);
            errors++;
        end
        // Most significant byte arrives first
        for (int k = 0; k < 4; k++) begin
            d = {d[23:0], tx_byte_o};
            step(1);
        end
    endtask

    task automatic core_access(input logic we, input addr_t a, input word_t wd,
                               output word_t rd, output int lat);
        core_stb_i   = 1'b1;
        core_we_i    = we;
        core_addr_i  = a;
        core_wdata_i = wd;
        lat          = 0;
        do begin
            step(1);
            lat++;
        end while (!core_ack_o && lat < 10);
        rd         = core_rdata_o;
        core_stb_i = 1'b0;
        step(1);
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        word_t got;
        int    lat;
        rst_n_i      = 1'b0;
        rx_byte_i    = '0;
        rx_valid_i   = 1'b0;
        core_stb_i   = 1'b0;
        core_we_i    = 1'b0;
        core_addr_i  = '0;
        core_wdata_i = '0;
        // Low address bits walk through every bank
        for (int i = 0; i < NWORDS; i++) begin
            addrs[i] = addr_t'(next_word());
            addrs[i][BANK_W-1:0] = BANK_W'(i);
        end

        // Core asks for memory during reset and boot
        core_addr_i = addrs[0];
        core_stb_i  = 1'b1;
        // Internal reset reaches the controller and banks within three edges
        step(3);
        repeat (5) begin
            check_word("core_rst_o", 32'(core_rst_o), 32'd1);
            check_word("core_ack_o", 32'(core_ack_o), 32'd0);
            step(1);
        end
        rst_n_i = 1'b1;
        repeat (`HARNESS_BOOT_CYCLES + 10) begin
            check_word("core_rst_o", 32'(core_rst_o), 32'd1);
            check_word("core_ack_o", 32'(core_ack_o), 32'd0);
            step(1);
        end
        core_stb_i = 1'b0;
        step(1);
        end_test("boot and hold");

        for (int i = 0; i < NWORDS; i++) begin
            model[addrs[i]] = next_word();
            host_write(addrs[i], model[addrs[i]]);
        end
        for (int i = 0; i < NWORDS; i++) begin
            host_read(addrs[i], got);
            check_word("tx_byte_o word", got, model[addrs[i]]);
        end
        end_test("host write and read-back");

        send_byte(RUN);
        check_word("core_rst_o", 32'(core_rst_o), 32'd0);
        for (int i = 0; i < NWORDS; i++) begin
            core_access(1'b0, addrs[i], '0, got, lat);
            check_word("core_rdata_o", got, model[addrs[i]]);
            check_word("core_ack_o latency", 32'(lat), 32'd1);
        end
        end_test("run and core fetch");

        for (int i = 0; i < NWORDS / 2; i++) begin
            model[addrs[i]] = next_word();
            core_access(1'b1, addrs[i], model[addrs[i]], got, lat);
            check_word("core_ack_o latency", 32'(lat), 32'd1);
        end
        send_byte(HALT);
        check_word("core_rst_o", 32'(core_rst_o), 32'd1);
        for (int i = 0; i < NWORDS; i++) begin
            host_read(addrs[i], got);
            check_word("tx_byte_o word", got, model[addrs[i]]);
        end
        end_test("core write, halt, host check");

        // Host write while the core owns memory must be dropped
        send_byte(RUN);
        host_write(addrs[NWORDS-1], next_word());
        send_byte(HALT);
        host_read(addrs[NWORDS-1], got);
        check_word("tx_byte_o word", got, model[addrs[NWORDS-1]]);
        end_test("ownership exclusion");

        $display("Checks: %0d, errors: %0d, property failures: %0d",
                 checks, errors, uut.u_props.prop_fails);
        if (errors == 0 && uut.u_props.prop_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the pass line
rm -rf obj_dir sim.log &&
verilator --binary --assert --top-module harness_tb -f sources.f -o harness_sim &&
./obj_dir/harness_sim +verilator+error+limit+100 > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sources.f ====
+incdir+src
src/harness_pkg.sv
src/mem_req_if.sv
src/reset_boot.sv
src/host_ctrl.sv
src/bank_router.sv
src/mem_bank.sv
src/read_collector.sv
src/harness_top.sv
dv/harness_properties.sv
dv/harness_tb.sv

// ==== src/bank_router.sv ====
`timescale 1ns/1ps
`include "harness_settings.svh"
`default_nettype none

module bank_router (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          core_rst_i,
    mem_req_if.slave                     host,
    mem_req_if.slave                     core,
    mem_req_if.master                    bank [`HARNESS_BANKS],
    output harness_pkg::bank_idx_t       sel_bank_o,
    output logic                         sel_host_o
);
    import harness_pkg::*;

    logic      owner_stb;
    logic      owner_we;
    addr_t     owner_addr;
    word_t     owner_wdata;
    bank_idx_t sel_now;
    row_t      owner_row;

    // Core reset decides who owns the memory
    always_comb begin
        if (core_rst_i) begin
            owner_stb   = host.stb;
            owner_we    = host.we;
            owner_addr  = host.addr;
            owner_wdata = host.wdata;
        end else begin
            owner_stb   = core.stb;
            owner_we    = core.we;
            owner_addr  = core.addr;
            owner_wdata = core.wdata;
        end
    end

    // Low bits pick the bank, the rest is the row
    assign sel_now   = bank_idx_t'(owner_addr);
    assign owner_row = row_t'(owner_addr >> $bits(bank_idx_t));

    for (genvar i = 0; i < `HARNESS_BANKS; i++) begin : g_bank
        assign bank[i].stb   = owner_stb && (sel_now == bank_idx_t'(i));
        assign bank[i].we    = owner_we;
        assign bank[i].addr  = addr_t'(owner_row);
        assign bank[i].wdata = owner_wdata;
    end

    // Selection of the access in flight, for the collector
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sel_bank_o <= '0;
            sel_host_o <= 1'b1;
        end else if (owner_stb) begin
            sel_bank_o <= sel_now;
            sel_host_o <= core_rst_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/harness_pkg.sv ====
`include "harness_settings.svh"
`default_nettype none

package harness_pkg;

    // Derived widths for bank interleaving
    localparam int BANK_W = $clog2(`HARNESS_BANKS);
    localparam int ROW_W  = `HARNESS_ADDR_W - BANK_W;

    typedef logic [31:0]               word_t;
    typedef logic [`HARNESS_ADDR_W-1:0] addr_t;
    typedef logic [BANK_W-1:0]         bank_idx_t;
    typedef logic [ROW_W-1:0]          row_t;
    typedef logic [7:0]                byte_t;

    // Host opcodes
    typedef enum logic [7:0] {
        WRITE = 8'h01,
        READ  = 8'h02,
        RUN   = 8'h03,
        HALT  = 8'h04
    } host_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        DATA,
        ACCESS,
        REPLY
    } host_state_t;

endpackage

`default_nettype wire

// ==== src/harness_settings.svh ====
`ifndef HARNESS_SETTINGS_SVH
`define HARNESS_SETTINGS_SVH

// Number of interleaved memory banks, power of two
`define HARNESS_BANKS 4

// Word address width of the shared memory
`define HARNESS_ADDR_W 10

// Cycles the internal reset stays low after the external reset
`define HARNESS_BOOT_CYCLES 20

`endif

// ==== src/harness_top.sv ====
`timescale 1ns/1ps
`include "harness_settings.svh"
`default_nettype none

module harness_top (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire harness_pkg::byte_t rx_byte_i,
    input  wire                     rx_valid_i,
    output harness_pkg::byte_t      tx_byte_o,
    output logic                    tx_valid_o,
    output logic                    core_rst_o,
    input  wire                     core_stb_i,
    input  wire                     core_we_i,
    input  wire harness_pkg::addr_t core_addr_i,
    input  wire harness_pkg::word_t core_wdata_i,
    output harness_pkg::word_t      core_rdata_o,
    output logic                    core_ack_o
);
    import harness_pkg::*;

    logic      sys_rst_n;
    bank_idx_t sel_bank;
    logic      sel_host;

    mem_req_if host_bus ();
    mem_req_if core_bus ();
    mem_req_if bank_bus [`HARNESS_BANKS] ();

    // Core side of the memory
    assign core_bus.stb   = core_stb_i;
    assign core_bus.we    = core_we_i;
    assign core_bus.addr  = core_addr_i;
    assign core_bus.wdata = core_wdata_i;
    assign core_rdata_o   = core_bus.rdata;
    assign core_ack_o     = core_bus.ack;

    reset_boot u_reset_boot (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .sys_rst_n_o (sys_rst_n)
    );

    host_ctrl u_host_ctrl (
        .clk        (clk),
        .rst_n_i    (sys_rst_n),
        .rx_byte_i  (rx_byte_i),
        .rx_valid_i (rx_valid_i),
        .tx_byte_o  (tx_byte_o),
        .tx_valid_o (tx_valid_o),
        .core_rst_o (core_rst_o),
        .mem        (host_bus)
    );

    bank_router u_bank_router (
        .clk        (clk),
        .rst_n_i    (sys_rst_n),
        .core_rst_i (core_rst_o),
        .host       (host_bus),
        .core       (core_bus),
        .bank       (bank_bus),
        .sel_bank_o (sel_bank),
        .sel_host_o (sel_host)
    );

    // Word-interleaved banks
    for (genvar i = 0; i < `HARNESS_BANKS; i++) begin : g_banks
        mem_bank u_mem_bank (
            .clk (clk),
            .bus (bank_bus[i])
        );
    end

    read_collector u_read_collector (
        .sel_bank_i (sel_bank),
        .sel_host_i (sel_host),
        .bank       (bank_bus),
        .host       (host_bus),
        .core       (core_bus)
    );

endmodule

`default_nettype wire

// ==== src/host_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_ctrl (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire harness_pkg::byte_t rx_byte_i,
    input  wire                     rx_valid_i,
    output harness_pkg::byte_t      tx_byte_o,
    output logic                    tx_valid_o,
    output logic                    core_rst_o,
    mem_req_if.master               mem
);
    import harness_pkg::*;

    host_state_t state;
    logic        is_write;
    logic [1:0]  byte_cnt;
    logic        stb_q;
    logic        host_owns;
    byte_t       addr_hi;
    byte_t       addr_lo;
    word_t       data_buf;

    // Host owns the memory only while the core is held
    assign host_owns = core_rst_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state      <= IDLE;
            is_write   <= 1'b0;
            byte_cnt   <= '0;
            stb_q      <= 1'b0;
            core_rst_o <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    byte_cnt <= '0;
                    if (rx_valid_i) begin
                        case (rx_byte_i)
                            WRITE: begin
                                is_write <= 1'b1;
                                state    <= ADDR;
                            end
                            READ: begin
                                is_write <= 1'b0;
                                state    <= ADDR;
                            end
                            RUN:     core_rst_o <= 1'b0;
                            HALT:    core_rst_o <= 1'b1;
                            default: ;
                        endcase
                    end
                end

                // Two address bytes, high byte first
                ADDR: begin
                    if (rx_valid_i) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd1) begin
                            byte_cnt <= '0;
                            if (is_write) begin
                                state <= DATA;
                            end else if (host_owns) begin
                                state <= ACCESS;
                                stb_q <= 1'b1;
                            end else begin
                                // Core is running, read dropped
                                state <= IDLE;
                            end
                        end
                    end
                end

                // Four data bytes, count wraps back to zero
                DATA: begin
                    if (rx_valid_i) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            if (host_owns) begin
                                state <= ACCESS;
                                stb_q <= 1'b1;
                            end else begin
                                state <= IDLE;
                            end
                        end
                    end
                end

                ACCESS: begin
                    if (mem.ack) begin
                        stb_q    <= 1'b0;
                        byte_cnt <= '0;
                        state    <= is_write ? IDLE : REPLY;
                    end
                end

                // One reply byte per cycle
                REPLY: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'd3) begin
                        state <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // Address, write data and reply shift register
    always_ff @(posedge clk) begin
        if (rx_valid_i && state == ADDR) begin
            addr_hi <= addr_lo;
            addr_lo <= rx_byte_i;
        end
        if (rx_valid_i && state == DATA) begin
            data_buf <= {data_buf[23:0], rx_byte_i};
        end else if (state == ACCESS && mem.ack && !is_write) begin
            data_buf <= mem.rdata;
        end else if (state == REPLY) begin
            data_buf <= {data_buf[23:0], 8'h00};
        end
    end

    assign mem.stb   = stb_q;
    assign mem.we    = is_write;
    assign mem.addr  = addr_t'({addr_hi, addr_lo});
    assign mem.wdata = data_buf;

    // Most significant byte goes out first
    assign tx_byte_o  = data_buf[31:24];
    assign tx_valid_o = (state == REPLY);

endmodule

`default_nettype wire

// ==== src/mem_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_bank (
    input  wire      clk,
    mem_req_if.slave bus
);
    import harness_pkg::*;

    localparam int DEPTH = 1 << $bits(row_t);

    word_t mem [DEPTH];
    row_t  row;
    word_t rdata_q;
    logic  ack_q;

    assign row = row_t'(bus.addr);

    // A held request is served once, stb is ignored during ack
    always_ff @(posedge clk) begin
        if (bus.stb && !ack_q) begin
            if (bus.we) begin
                mem[row] <= bus.wdata;
            end
            rdata_q <= mem[row];
        end
    end

    // Clears itself while the router keeps stb low in reset
    always_ff @(posedge clk) begin
        ack_q <= bus.stb && !ack_q;
    end

    assign bus.rdata = rdata_q;
    assign bus.ack   = ack_q;

endmodule

`default_nettype wire

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One memory request with its response
interface mem_req_if;
    import harness_pkg::*;

    // Request side, held stable until ack
    logic  stb;
    logic  we;
    addr_t addr;
    word_t wdata;

    // Response side
    word_t rdata;
    logic  ack;

    modport master (
        output stb,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport slave (
        input  stb,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

// ==== src/read_collector.sv ====
`timescale 1ns/1ps
`include "harness_settings.svh"
`default_nettype none

module read_collector (
    input  wire harness_pkg::bank_idx_t sel_bank_i,
    input  wire                         sel_host_i,
    mem_req_if.slave                    bank [`HARNESS_BANKS],
    mem_req_if.slave                    host,
    mem_req_if.slave                    core
);
    import harness_pkg::*;

    word_t                    bank_rdata [`HARNESS_BANKS];
    logic [`HARNESS_BANKS-1:0] bank_ack;
    word_t                    sel_rdata;
    logic                     sel_ack;

    // Flatten the bank responses so they can be indexed at run time
    for (genvar i = 0; i < `HARNESS_BANKS; i++) begin : g_gather
        assign bank_rdata[i] = bank[i].rdata;
        assign bank_ack[i]   = bank[i].ack;
    end

    assign sel_rdata = bank_rdata[sel_bank_i];
    assign sel_ack   = bank_ack[sel_bank_i];

    // Data may go to both, ack only to the requester
    assign host.rdata = sel_rdata;
    assign core.rdata = sel_rdata;
    assign host.ack   = sel_ack && sel_host_i;
    assign core.ack   = sel_ack && !sel_host_i;

endmodule

`default_nettype wire

// ==== src/reset_boot.sv ====
`timescale 1ns/1ps
`include "harness_settings.svh"
`default_nettype none

module reset_boot (
    input  wire  clk,
    input  wire  rst_n_i,
    output logic sys_rst_n_o
);

    localparam int unsigned BOOT_CYCLES = `HARNESS_BOOT_CYCLES;
    localparam int unsigned CNT_W       = $clog2(BOOT_CYCLES + 1);

    logic [CNT_W-1:0] boot_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            boot_cnt    <= '0;
            sys_rst_n_o <= 1'b0;
        end else begin
            // Saturates once the boot time is reached
            if (boot_cnt != CNT_W'(BOOT_CYCLES)) begin
                boot_cnt <= boot_cnt + 1'b1;
            end
            // Released on the last counted edge
            sys_rst_n_o <= (boot_cnt >= CNT_W'(BOOT_CYCLES - 1));
        end
    end

endmodule

`default_nettype wire
